/* include/mhq_consts.svh */
/*
 * Sizing shared by the miss queue RTL and its testbench.
 * LINE_BEATS, OFFSET_WIDTH and MHQ_TAG_WIDTH are derived by hand and must
 * stay consistent with LINE_SIZE, WORD_SIZE and MHQ_DEPTH.
 */
`ifndef MHQ_CONSTS_SVH
`define MHQ_CONSTS_SVH

// Byte address width of the memory bus
`define ADDR_WIDTH      32

// Bus word and cache line sizes in bytes
`define WORD_SIZE       4
`define LINE_SIZE       16
`define LINE_BEATS      4
`define OFFSET_WIDTH    4

// Miss queue depth and the width of an entry index
`define MHQ_DEPTH       4
`define MHQ_TAG_WIDTH   2

`endif

/* design/mhq_pkg.sv */
/*
 * Types shared by the miss subsystem. Widths come from the constants header.
 */
`default_nettype none

`include "mhq_consts.svh"

package mhq_pkg;

    typedef logic [`ADDR_WIDTH-1:0]    addr_t;
    typedef logic [8*`WORD_SIZE-1:0]   data_t;
    typedef logic [8*`LINE_SIZE-1:0]   line_t;
    typedef logic [`WORD_SIZE-1:0]     byte_sel_t;
    typedef logic [`MHQ_TAG_WIDTH-1:0] mhq_tag_t;

    // One load or store miss presented to the queue
    typedef struct packed {
        logic      en;
        logic      we;
        addr_t     addr;
        data_t     data;
        byte_sel_t byte_sel;
    } enq_req_t;

    // Completed line with the store bytes already merged in
    typedef struct packed {
        logic     valid;
        mhq_tag_t tag;
        logic     dirty;
        addr_t    addr;
        line_t    data;
    } fill_t;

    // Wishbone classic master outputs
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        addr_t     adr;
        data_t     dat;
        byte_sel_t sel;
    } wb_req_t;

    // Wishbone classic slave outputs
    typedef struct packed {
        logic  ack;
        data_t dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* design/miss_handling_queue.sv */
/*
 * Miss queue keyed by cache line address. A store must not cross a line
 * boundary, bytes past the end of the line are dropped. A flush also drops
 * an enqueue presented in the same cycle.
 */
`timescale 1ns/10ps
`default_nettype none

`include "mhq_consts.svh"

module miss_handling_queue (
    input  logic              clk,
    input  logic              n_rst,
    input  logic              i_flush,
    input  mhq_pkg::enq_req_t i_enq,
    output mhq_pkg::mhq_tag_t o_enq_tag,
    output logic              o_full,
    output logic              o_fetch_en,
    output mhq_pkg::addr_t    o_fetch_addr,
    input  logic              i_fetch_done,
    input  mhq_pkg::line_t    i_fetch_data,
    output mhq_pkg::fill_t    o_fill
);

    typedef logic [`ADDR_WIDTH-`OFFSET_WIDTH-1:0] line_addr_t;
    typedef logic [`LINE_SIZE-1:0]                line_mask_t;
    typedef logic [`MHQ_TAG_WIDTH:0]              ptr_t;

    logic [`MHQ_DEPTH-1:0]    ent_valid;
    logic [`MHQ_DEPTH-1:0]    ent_dirty;
    line_addr_t               ent_addr [`MHQ_DEPTH];
    mhq_pkg::line_t           ent_data [`MHQ_DEPTH];
    line_mask_t               ent_mask [`MHQ_DEPTH];

    ptr_t                     head;
    ptr_t                     tail;
    mhq_pkg::mhq_tag_t        head_idx;
    mhq_pkg::mhq_tag_t        tail_idx;
    mhq_pkg::mhq_tag_t        match_idx;
    logic [`MHQ_DEPTH-1:0]    match;
    logic [`MHQ_DEPTH-1:0]    enq_sel;
    logic                     full;
    logic                     hit;
    logic                     merging;
    logic                     allocating;
    line_addr_t               enq_line;
    logic [`OFFSET_WIDTH-1:0] enq_offset;
    line_mask_t               enq_mask;
    mhq_pkg::line_t           enq_data;

    assign head_idx = head[`MHQ_TAG_WIDTH-1:0];
    assign tail_idx = tail[`MHQ_TAG_WIDTH-1:0];

    // Full when the pointers share an index but differ in the wrap bit
    assign full = ({~tail[`MHQ_TAG_WIDTH], tail_idx} == head);

    assign enq_line   = i_enq.addr[`ADDR_WIDTH-1:`OFFSET_WIDTH];
    assign enq_offset = i_enq.addr[`OFFSET_WIDTH-1:0];

    // Store bytes and their mask moved to their place in the line
    assign enq_mask = {{(`LINE_SIZE-`WORD_SIZE){1'b0}}, i_enq.byte_sel} << enq_offset;
    assign enq_data = {{(8*(`LINE_SIZE-`WORD_SIZE)){1'b0}}, i_enq.data} << {enq_offset, 3'b000};

    // The head entry stops taking merges in its fill cycle, since its fill is already built
    always_comb begin
        match     = '0;
        match_idx = '0;
        for (int i = 0; i < `MHQ_DEPTH; i++) begin
            if (ent_valid[i] && (ent_addr[i] == enq_line) &&
                !(i_fetch_done && (mhq_pkg::mhq_tag_t'(i) == head_idx))) begin
                match[i]  = 1'b1;
                match_idx = mhq_pkg::mhq_tag_t'(i);
            end
        end
    end

    assign hit        = |match;
    assign merging    = i_enq.en && hit && !i_flush;
    assign allocating = i_enq.en && !hit && !full && !i_flush;
    assign enq_sel    = merging ? match : ({{(`MHQ_DEPTH-1){1'b0}}, allocating} << tail_idx);

    assign o_enq_tag    = hit ? match_idx : tail_idx;
    assign o_full       = full;
    assign o_fetch_en   = ent_valid[head_idx];
    assign o_fetch_addr = {ent_addr[head_idx], {`OFFSET_WIDTH{1'b0}}};

    // Memory bytes fill every position that no store has touched
    always_comb begin
        o_fill.valid = i_fetch_done;
        o_fill.tag   = head_idx;
        o_fill.dirty = ent_dirty[head_idx];
        o_fill.addr  = {ent_addr[head_idx], {`OFFSET_WIDTH{1'b0}}};
        for (int j = 0; j < `LINE_SIZE; j++) begin
            o_fill.data[j*8 +: 8] = ent_mask[head_idx][j] ? ent_data[head_idx][j*8 +: 8]
                                                          : i_fetch_data[j*8 +: 8];
        end
    end

    // Flush clears all but the head, a fill retires the head
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            ent_valid <= '0;
        end else begin
            for (int i = 0; i < `MHQ_DEPTH; i++) begin
                if (i_flush && (mhq_pkg::mhq_tag_t'(i) != head_idx)) begin
                    ent_valid[i] <= 1'b0;
                end else if (i_fetch_done && (mhq_pkg::mhq_tag_t'(i) == head_idx)) begin
                    ent_valid[i] <= 1'b0;
                end else if (allocating && enq_sel[i]) begin
                    ent_valid[i] <= 1'b1;
                end
            end
        end
    end

    // A new entry starts clean, a merge accumulates dirty state and store bytes
    always_ff @(posedge clk) begin
        for (int i = 0; i < `MHQ_DEPTH; i++) begin
            if (enq_sel[i]) begin
                ent_addr[i]  <= enq_line;
                ent_dirty[i] <= i_enq.we | (merging & ent_dirty[i]);
                ent_mask[i]  <= (i_enq.we ? enq_mask : '0) | (merging ? ent_mask[i] : '0);
                for (int j = 0; j < `LINE_SIZE; j++) begin
                    if (i_enq.we && enq_mask[j]) begin
                        ent_data[i][j*8 +: 8] <= enq_data[j*8 +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (i_fetch_done) begin
                head <= head + 1'b1;
            end
            // After a flush only the head can remain queued
            if (i_flush) begin
                tail <= ent_valid[head_idx] ? head + 1'b1 : head;
            end else if (allocating) begin
                tail <= tail + 1'b1;
            end
        end
    end

    a_alloc_free: assert property (@(posedge clk) disable iff (!n_rst)
        allocating |-> !ent_valid[tail_idx])
        else $error("MHQ allocated over a live entry");

    a_done_req: assert property (@(posedge clk) disable iff (!n_rst)
        i_fetch_done |-> o_fetch_en)
        else $error("Fetch done without a pending fetch request");

endmodule

`default_nettype wire

/* design/line_fetcher.sv */
/*
 * Reads one cache line as LINE_BEATS Wishbone classic read beats.
 * A fetch starts only while the writeback engine is idle.
 */
`timescale 1ns/10ps
`default_nettype none

`include "mhq_consts.svh"

module line_fetcher (
    input  logic             clk,
    input  logic             n_rst,
    input  logic             i_fetch_en,
    input  mhq_pkg::addr_t   i_fetch_addr,
    input  logic             i_writer_busy,
    output logic             o_done,
    output mhq_pkg::line_t   o_data,
    output mhq_pkg::wb_req_t o_wb,
    input  mhq_pkg::wb_rsp_t i_wb
);

    localparam int WORD_BITS = $clog2(`WORD_SIZE);
    localparam int BEAT_BITS = $clog2(`LINE_BEATS);

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_READ,
        FETCH_DONE
    } fetch_state_t;

    fetch_state_t                         state;
    logic [BEAT_BITS-1:0]                 beat;
    logic [`ADDR_WIDTH-`OFFSET_WIDTH-1:0] line_addr;
    mhq_pkg::line_t                       line_q;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state <= FETCH_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (i_fetch_en && !i_writer_busy) begin
                        state <= FETCH_READ;
                    end
                end
                FETCH_READ: begin
                    if (i_wb.ack) begin
                        beat <= beat + 1'b1;
                        if (beat == BEAT_BITS'(`LINE_BEATS - 1)) begin
                            state <= FETCH_DONE;
                        end
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // Words arrive lowest first and are shifted in from the top
    always_ff @(posedge clk) begin
        if ((state == FETCH_IDLE) && i_fetch_en && !i_writer_busy) begin
            line_addr <= i_fetch_addr[`ADDR_WIDTH-1:`OFFSET_WIDTH];
        end
        if ((state == FETCH_READ) && i_wb.ack) begin
            line_q <= {i_wb.dat, line_q[8*`LINE_SIZE-1:8*`WORD_SIZE]};
        end
    end

    assign o_wb.cyc = (state == FETCH_READ);
    assign o_wb.stb = (state == FETCH_READ);
    assign o_wb.we  = 1'b0;
    assign o_wb.adr = {line_addr, beat, {WORD_BITS{1'b0}}};
    assign o_wb.dat = '0;
    assign o_wb.sel = '1;
    assign o_done   = (state == FETCH_DONE);
    assign o_data   = line_q;

endmodule

`default_nettype wire

/* design/line_writeback.sv */
/*
 * Writes each dirty fill back to memory as LINE_BEATS full-word writes.
 * Only one line is held, so dirty fills must be spaced by a full writeback.
 */
`timescale 1ns/10ps
`default_nettype none

`include "mhq_consts.svh"

module line_writeback (
    input  logic             clk,
    input  logic             n_rst,
    input  mhq_pkg::fill_t   i_fill,
    output logic             o_busy,
    output mhq_pkg::wb_req_t o_wb,
    input  mhq_pkg::wb_rsp_t i_wb
);

    localparam int WORD_BITS = $clog2(`WORD_SIZE);
    localparam int BEAT_BITS = $clog2(`LINE_BEATS);

    logic                                 busy;
    logic                                 capture;
    logic [BEAT_BITS-1:0]                 beat;
    logic [`ADDR_WIDTH-`OFFSET_WIDTH-1:0] line_addr;
    mhq_pkg::line_t                       line_q;

    assign capture = i_fill.valid && i_fill.dirty && !busy;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            busy <= 1'b0;
            beat <= '0;
        end else if (capture) begin
            busy <= 1'b1;
        end else if (busy && i_wb.ack) begin
            beat <= beat + 1'b1;
            if (beat == BEAT_BITS'(`LINE_BEATS - 1)) begin
                busy <= 1'b0;
            end
        end
    end

    // The current word always sits at the bottom of the line register
    always_ff @(posedge clk) begin
        if (capture) begin
            line_addr <= i_fill.addr[`ADDR_WIDTH-1:`OFFSET_WIDTH];
            line_q    <= i_fill.data;
        end else if (busy && i_wb.ack) begin
            line_q <= line_q >> (8*`WORD_SIZE);
        end
    end

    assign o_wb.cyc = busy;
    assign o_wb.stb = busy;
    assign o_wb.we  = 1'b1;
    assign o_wb.adr = {line_addr, beat, {WORD_BITS{1'b0}}};
    assign o_wb.dat = line_q[8*`WORD_SIZE-1:0];
    assign o_wb.sel = '1;
    assign o_busy   = busy;

    a_no_overlap: assert property (@(posedge clk) disable iff (!n_rst)
        (i_fill.valid && i_fill.dirty) |-> !busy)
        else $error("Dirty fill arrived during a writeback");

endmodule

`default_nettype wire

/* design/wb_arbiter.sv */
/*
 * Two-master Wishbone classic arbiter. Ownership changes only when the
 * current owner has dropped cyc, and the writeback master wins a tie.
 */
`timescale 1ns/10ps
`default_nettype none

module wb_arbiter (
    input  logic             clk,
    input  logic             n_rst,
    input  mhq_pkg::wb_req_t i_req_fetch,
    input  mhq_pkg::wb_req_t i_req_wb,
    output mhq_pkg::wb_rsp_t o_rsp_fetch,
    output mhq_pkg::wb_rsp_t o_rsp_wb,
    output mhq_pkg::wb_req_t o_bus,
    input  mhq_pkg::wb_rsp_t i_bus
);

    logic owner_wb;
    logic owner_cyc;
    logic grant_wb;

    assign owner_cyc = owner_wb ? i_req_wb.cyc : i_req_fetch.cyc;

    // Keep the owner through its cycle, otherwise pick afresh
    assign grant_wb = owner_cyc ? owner_wb : i_req_wb.cyc;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            owner_wb <= 1'b0;
        end else begin
            owner_wb <= grant_wb;
        end
    end

    assign o_bus = grant_wb ? i_req_wb : i_req_fetch;

    assign o_rsp_fetch.ack = i_bus.ack && !grant_wb;
    assign o_rsp_fetch.dat = i_bus.dat;
    assign o_rsp_wb.ack    = i_bus.ack && grant_wb;
    assign o_rsp_wb.dat    = i_bus.dat;

    // The slave may only acknowledge the strobe of the master that owns the bus
    a_ack_owner: assert property (@(posedge clk) disable iff (!n_rst)
        i_bus.ack |-> (grant_wb ? i_req_wb.stb : i_req_fetch.stb))
        else $error("Bus ack without a strobe from the owner");

endmodule

`default_nettype wire

/* design/mhq_subsystem.sv */
/*
 * Miss subsystem top. One external Wishbone classic master port is shared
 * by the line fetcher and the writeback engine.
 */
`timescale 1ns/10ps
`default_nettype none

module mhq_subsystem (
    input  logic              clk,
    input  logic              n_rst,
    input  logic              i_flush,
    input  mhq_pkg::enq_req_t i_enq,
    output mhq_pkg::mhq_tag_t o_enq_tag,
    output logic              o_full,
    output mhq_pkg::fill_t    o_fill,
    output mhq_pkg::wb_req_t  o_bus,
    input  mhq_pkg::wb_rsp_t  i_bus
);

    logic             fetch_en;
    mhq_pkg::addr_t   fetch_addr;
    logic             fetch_done;
    mhq_pkg::line_t   fetch_data;
    logic             writer_busy;
    mhq_pkg::wb_req_t fetch_req;
    mhq_pkg::wb_rsp_t fetch_rsp;
    mhq_pkg::wb_req_t wb_req;
    mhq_pkg::wb_rsp_t wb_rsp;

    miss_handling_queue mhq_i (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_flush      (i_flush),
        .i_enq        (i_enq),
        .o_enq_tag    (o_enq_tag),
        .o_full       (o_full),
        .o_fetch_en   (fetch_en),
        .o_fetch_addr (fetch_addr),
        .i_fetch_done (fetch_done),
        .i_fetch_data (fetch_data),
        .o_fill       (o_fill)
    );

    line_fetcher fetcher_i (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_fetch_en    (fetch_en),
        .i_fetch_addr  (fetch_addr),
        .i_writer_busy (writer_busy),
        .o_done        (fetch_done),
        .o_data        (fetch_data),
        .o_wb          (fetch_req),
        .i_wb          (fetch_rsp)
    );

    // Sees every fill and writes back only the dirty ones
    line_writeback writeback_i (
        .clk    (clk),
        .n_rst  (n_rst),
        .i_fill (o_fill),
        .o_busy (writer_busy),
        .o_wb   (wb_req),
        .i_wb   (wb_rsp)
    );

    wb_arbiter arbiter_i (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_req_fetch (fetch_req),
        .i_req_wb    (wb_req),
        .o_rsp_fetch (fetch_rsp),
        .o_rsp_wb    (wb_rsp),
        .o_bus       (o_bus),
        .i_bus       (i_bus)
    );

endmodule

`default_nettype wire

/* sim/wb_mem_model.sv */
/*
 * Wishbone classic memory slave with a registered ack after 0 to MAX_WAIT
 * extra cycles. Only the low WORDS words are decoded, higher bits alias.
 */
`timescale 1ns/10ps
`default_nettype none

module wb_mem_model #(
    parameter logic [31:0] SEED     = 32'd1,
    parameter int          MAX_WAIT = 3,
    parameter int          WORDS    = 64
) (
    input  logic             clk,
    input  logic             n_rst,
    input  mhq_pkg::wb_req_t i_wb,
    output mhq_pkg::wb_rsp_t o_wb
);

    localparam int IDX_BITS = $clog2(WORDS);

    logic [31:0]         mem [WORDS];
    logic [31:0]         rng;
    int                  wait_cnt;
    int                  wait_target;
    logic [IDX_BITS-1:0] idx;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Each word is scrambled from the seed and its full byte address
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = xorshift32(SEED ^ 32'(i * 4));
        end
    end

    assign idx = i_wb.adr[IDX_BITS+1:2];

    always @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            o_wb        <= '0;
            rng         <= SEED;
            wait_cnt    <= 0;
            wait_target <= 0;
        end else if (o_wb.ack) begin
            // The master moves on at this edge, so pick the next beat's wait
            o_wb.ack    <= 1'b0;
            rng         <= xorshift32(rng);
            wait_target <= int'(rng % (MAX_WAIT + 1));
            wait_cnt    <= 0;
        end else if (i_wb.cyc && i_wb.stb) begin
            if (wait_cnt == wait_target) begin
                o_wb.ack <= 1'b1;
                if (i_wb.we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (i_wb.sel[b]) begin
                            mem[idx][8*b +: 8] <= i_wb.dat[8*b +: 8];
                        end
                    end
                end else begin
                    o_wb.dat <= mem[idx];
                end
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end
    end

endmodule

`default_nettype wire

/* sim/mhq_tb.sv */
/*
 * Testbench for the miss subsystem. Addresses stay below 256 bytes so the
 * memory model and the reference copy hold 64 words.
 */
`timescale 1ns/10ps
`default_nettype none

`include "mhq_consts.svh"

module mhq_tb;

    localparam logic [31:0] SEED           = 32'd38923;
    localparam int          MEM_WORDS      = 64;
    localparam int          MAX_WAIT       = 3;
    localparam int          BEAT_WORST     = MAX_WAIT + 2;
    localparam int          FETCH_WORST    = 2 + `LINE_BEATS * BEAT_WORST;
    localparam int          WB_WORST       = 1 + `LINE_BEATS * BEAT_WORST;
    localparam int          STEP_WORST     = 6;
    localparam int          RANDOM_REQS    = 300;
    localparam int          DIRECTED_REQS  = 15;
    localparam int          TIMEOUT_CYCLES = (RANDOM_REQS + DIRECTED_REQS) *
                                             (FETCH_WORST + WB_WORST + STEP_WORST) + 1000;

    logic               clk;
    logic               n_rst;
    logic               flush;
    mhq_pkg::enq_req_t  enq;
    mhq_pkg::mhq_tag_t  enq_tag;
    logic               full;
    mhq_pkg::fill_t     fill;
    mhq_pkg::wb_req_t   bus_req;
    mhq_pkg::wb_rsp_t   bus_rsp;

    // Reference model of the queue and of memory
    logic [`MHQ_TAG_WIDTH:0] m_head;
    logic [`MHQ_TAG_WIDTH:0] m_tail;
    logic                    sh_valid [`MHQ_DEPTH];
    logic                    sh_dirty [`MHQ_DEPTH];
    mhq_pkg::addr_t          sh_line  [`MHQ_DEPTH];
    logic [7:0]              sh_byte  [`MHQ_DEPTH][`LINE_SIZE];
    logic                    sh_mask  [`MHQ_DEPTH][`LINE_SIZE];
    logic [31:0]             ref_mem  [MEM_WORDS];

    mhq_pkg::fill_t last_fill;
    logic [31:0]    rng_state;
    string          test_name;
    int             checks;
    int             errors;
    int             fills;
    int             cycles;

    mhq_subsystem dut_i (
        .clk       (clk),
        .n_rst     (n_rst),
        .i_flush   (flush),
        .i_enq     (enq),
        .o_enq_tag (enq_tag),
        .o_full    (full),
        .o_fill    (fill),
        .o_bus     (bus_req),
        .i_bus     (bus_rsp)
    );

    wb_mem_model #(.SEED(SEED), .MAX_WAIT(MAX_WAIT), .WORDS(MEM_WORDS)) mem_i (
        .clk   (clk),
        .n_rst (n_rst),
        .i_wb  (bus_req),
        .o_wb  (bus_rsp)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Initial memory word at a byte address
    function automatic logic [31:0] pattern_word(input logic [31:0] addr);
        return xorshift32(SEED ^ addr);
    endfunction

    function automatic int queued_count();
        logic [`MHQ_TAG_WIDTH:0] diff;
        diff = m_tail - m_head;
        return int'(diff);
    endfunction

    // Store bytes of an entry over the reference memory line
    function automatic logic [127:0] expected_line(input int idx);
        logic [127:0] merged;
        int           w;
        for (int j = 0; j < `LINE_SIZE; j++) begin
            w = int'(sh_line[idx][7:2]) + j / 4;
            merged[8*j +: 8] = sh_mask[idx][j] ? sh_byte[idx][j] : ref_mem[w][8*(j%4) +: 8];
        end
        return merged;
    endfunction

    task automatic compare_value(input string what, input logic [127:0] expected,
                                 input logic [127:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED %s: %s expected %0h actual %0h", test_name, what, expected, actual);
        end
    endtask

    task automatic check_condition(input logic cond, input string message);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Error in %s: %s", test_name, message);
        end
    endtask

    // Applies the request seen on the inputs to one shadow entry
    task automatic record_request(input int idx, input logic fresh);
        int w;
        w = int'(enq.addr[3:2]);
        if (fresh) begin
            sh_valid[idx] = 1'b1;
            sh_dirty[idx] = 1'b0;
            sh_line[idx]  = {enq.addr[31:4], 4'h0};
            for (int j = 0; j < `LINE_SIZE; j++) begin
                sh_mask[idx][j] = 1'b0;
            end
        end
        if (enq.we) begin
            sh_dirty[idx] = 1'b1;
            for (int b = 0; b < `WORD_SIZE; b++) begin
                if (enq.byte_sel[b]) begin
                    sh_mask[idx][4*w+b] = 1'b1;
                    sh_byte[idx][4*w+b] = enq.data[8*b +: 8];
                end
            end
        end
    endtask

    // Inputs and outputs are settled at the falling edge, the model
    // applies what the DUT will commit on the next rising edge
    always @(negedge clk) begin : monitor
        logic [`MHQ_TAG_WIDTH:0] old_ptr;
        mhq_pkg::mhq_tag_t       old_head;
        mhq_pkg::mhq_tag_t       exp_tag;
        logic                    head_live;
        logic                    hit;
        logic [127:0]            exp_line;
        if (n_rst) begin
            old_ptr   = m_head;
            old_head  = m_head[`MHQ_TAG_WIDTH-1:0];
            head_live = sh_valid[old_head];
            compare_value("o_full", queued_count() == `MHQ_DEPTH, full);
            if (enq.en && !flush) begin
                hit     = 1'b0;
                exp_tag = m_tail[`MHQ_TAG_WIDTH-1:0];
                // The head in its fill cycle no longer takes merges
                for (int i = 0; i < `MHQ_DEPTH; i++) begin
                    if (sh_valid[i] && (sh_line[i] == {enq.addr[31:4], 4'h0}) &&
                        !(fill.valid && (mhq_pkg::mhq_tag_t'(i) == old_head))) begin
                        hit     = 1'b1;
                        exp_tag = mhq_pkg::mhq_tag_t'(i);
                    end
                end
                if (hit || (queued_count() < `MHQ_DEPTH)) begin
                    compare_value("o_enq_tag", exp_tag, enq_tag);
                    record_request(int'(exp_tag), !hit);
                    if (!hit) begin
                        m_tail = m_tail + 1'b1;
                    end
                end
            end
            if (fill.valid) begin
                fills++;
                check_condition(head_live, "a fill arrived with no queued entry");
                if (head_live) begin
                    exp_line = expected_line(int'(old_head));
                    compare_value("fill tag", old_head, fill.tag);
                    compare_value("fill addr", sh_line[old_head], fill.addr);
                    compare_value("fill dirty", sh_dirty[old_head], fill.dirty);
                    compare_value("fill data", exp_line, fill.data);
                    if (sh_dirty[old_head]) begin
                        for (int w = 0; w < `LINE_BEATS; w++) begin
                            ref_mem[int'(sh_line[old_head][7:2]) + w] = exp_line[32*w +: 32];
                        end
                    end
                    sh_valid[old_head] = 1'b0;
                    m_head = m_head + 1'b1;
                end
                last_fill = fill;
            end
            if (flush) begin
                for (int i = 0; i < `MHQ_DEPTH; i++) begin
                    if (mhq_pkg::mhq_tag_t'(i) != old_head) begin
                        sh_valid[i] = 1'b0;
                    end
                end
                m_tail = head_live ? old_ptr + 1'b1 : old_ptr;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: no end of test after %0d cycles in %s", cycles, test_name);
            $display("Checks: %0d, fills: %0d, errors: %0d", checks, fills, errors);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Holds one request for a cycle and returns the tag the DUT offered
    task automatic present_request(input logic we, input logic [31:0] addr,
                                   input logic [31:0] data, input logic [3:0] sel,
                                   output mhq_pkg::mhq_tag_t tag);
        @(posedge clk);
        enq.en       <= 1'b1;
        enq.we       <= we;
        enq.addr     <= addr;
        enq.data     <= data;
        enq.byte_sel <= sel;
        flush        <= 1'b0;
        @(negedge clk);
        tag = enq_tag;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            enq.en <= 1'b0;
            flush  <= 1'b0;
        end
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        enq.en <= 1'b0;
        flush  <= 1'b1;
        @(posedge clk);
        flush  <= 1'b0;
    endtask

    // Waits for every queued entry to fill and any writeback to finish
    task automatic drain();
        while (queued_count() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        while (bus_req.cyc) begin
            @(negedge clk);
        end
    endtask

    initial begin
        mhq_pkg::mhq_tag_t tag_a;
        mhq_pkg::mhq_tag_t tag_b;
        mhq_pkg::mhq_tag_t tag_c;
        logic [31:0]       rnd;
        int                fills_start;
        clk       = 1'b0;
        n_rst     = 1'b0;
        flush     = 1'b0;
        enq       = '0;
        checks    = 0;
        errors    = 0;
        fills     = 0;
        cycles    = 0;
        m_head    = '0;
        m_tail    = '0;
        last_fill = '0;
        test_name = "reset";
        for (int i = 0; i < `MHQ_DEPTH; i++) begin
            sh_valid[i] = 1'b0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = pattern_word(32'(i * 4));
        end
        rng_state = SEED;
        repeat (5) @(posedge clk);
        n_rst <= 1'b1;

        test_name   = "load_miss";
        fills_start = fills;
        present_request(1'b0, 32'h84, 32'h0, 4'h0, tag_a);
        idle_cycles(1);
        drain();
        compare_value("fill count", 1, fills - fills_start);
        compare_value("fill addr", 32'h80, last_fill.addr);
        compare_value("fill dirty", 0, last_fill.dirty);
        compare_value("word 0", pattern_word(32'h80), last_fill.data[31:0]);

        test_name = "store_fill";
        present_request(1'b1, 32'h98, 32'hA1B2C3D4, 4'b0101, tag_a);
        idle_cycles(1);
        drain();
        compare_value("fill dirty", 1, last_fill.dirty);
        compare_value("word 2", (pattern_word(32'h98) & 32'hFF00FF00) | 32'h00B200D4,
                      last_fill.data[95:64]);

        test_name   = "merge";
        fills_start = fills;
        present_request(1'b0, 32'hA4, 32'h0, 4'h0, tag_a);
        present_request(1'b1, 32'hA0, 32'h11223344, 4'hF, tag_b);
        present_request(1'b1, 32'hAC, 32'h55667788, 4'b0011, tag_c);
        idle_cycles(1);
        drain();
        compare_value("second tag", tag_a, tag_b);
        compare_value("third tag", tag_a, tag_c);
        compare_value("fill count", 1, fills - fills_start);
        compare_value("word 0", 32'h11223344, last_fill.data[31:0]);
        compare_value("word 3", (pattern_word(32'hAC) & 32'hFFFF0000) | 32'h7788,
                      last_fill.data[127:96]);

        test_name   = "full";
        fills_start = fills;
        present_request(1'b0, 32'hB0, 32'h0, 4'h0, tag_a);
        present_request(1'b0, 32'hC0, 32'h0, 4'h0, tag_a);
        present_request(1'b0, 32'hD0, 32'h0, 4'h0, tag_a);
        present_request(1'b0, 32'hE0, 32'h0, 4'h0, tag_a);
        present_request(1'b0, 32'hF0, 32'h0, 4'h0, tag_a);
        compare_value("o_full", 1, full);
        idle_cycles(1);
        drain();
        compare_value("fill count", 4, fills - fills_start);
        compare_value("last fill addr", 32'hE0, last_fill.addr);

        // Line 0x90 was written back by the store test
        test_name = "writeback";
        present_request(1'b0, 32'h90, 32'h0, 4'h0, tag_a);
        idle_cycles(1);
        drain();
        compare_value("fill dirty", 0, last_fill.dirty);
        compare_value("word 2", (pattern_word(32'h98) & 32'hFF00FF00) | 32'h00B200D4,
                      last_fill.data[95:64]);

        test_name   = "flush";
        fills_start = fills;
        present_request(1'b1, 32'h54, 32'hCAFE0001, 4'hF, tag_a);
        present_request(1'b0, 32'h60, 32'h0, 4'h0, tag_b);
        present_request(1'b1, 32'h70, 32'hCAFE0002, 4'hF, tag_c);
        pulse_flush();
        idle_cycles(1);
        drain();
        compare_value("fill count", 1, fills - fills_start);
        compare_value("fill addr", 32'h50, last_fill.addr);
        present_request(1'b0, 32'h40, 32'h0, 4'h0, tag_b);
        compare_value("next tag", mhq_pkg::mhq_tag_t'(tag_a + 1'b1), tag_b);
        idle_cycles(1);
        drain();

        // Random loads and stores over lines 0 to 7 with rare flushes
        test_name = "random";
        for (int n = 0; n < RANDOM_REQS; n++) begin
            rnd = next_random();
            if (rnd[31:27] == 5'd0) begin
                pulse_flush();
            end
            present_request(rnd[0], {25'd0, rnd[3:1], rnd[5:4], 2'b00}, next_random(),
                            rnd[9:6], tag_a);
            idle_cycles(int'(rnd[11:10]));
        end
        idle_cycles(1);
        drain();

        $display("Checks: %0d, fills: %0d, errors: %0d", checks, fills, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
design/mhq_pkg.sv
design/miss_handling_queue.sv
design/line_fetcher.sv
design/line_writeback.sv
design/wb_arbiter.sv
design/mhq_subsystem.sv
sim/wb_mem_model.sv
sim/mhq_tb.sv

/* run.sh */
#!/bin/sh
# Builds the miss queue testbench with Verilator and runs it.
# The run fails on a build error, a bad exit status or a fail line in the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module mhq_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vmhq_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
exit 0
